// File: all.f
design/rvPkg.sv
design/controlUnit.sv
design/regFile.sv
design/immExtend.sv
design/hazardUnit.sv
design/forwardUnit.sv
design/alu.sv
design/processor.sv
tests/processor_asserts.sv
tests/processorTb.sv

// File: Bender.yml
package:
  name: rv_pipeline

sources:
  - design/rvPkg.sv
  - design/controlUnit.sv
  - design/regFile.sv
  - design/immExtend.sv
  - design/hazardUnit.sv
  - design/forwardUnit.sv
  - design/alu.sv
  - design/processor.sv
  - target: test
    files:
      - tests/processor_asserts.sv
      - tests/processorTb.sv

// File: tests/processorTb.sv
`timescale 1ns/10ps

module processorTb import rvPkg::*; ();

    localparam int numTests = 5;
    localparam int bodyLen = 44;
    // Body, then 15 dump stores, then ECALL
    localparam int progLen = bodyLen + 16;
    localparam int dumpBase = 64;
    localparam regName_t linkReg = 5'd20;
    localparam aluOp_t immOps [5] = '{ADD, AND, OR, XOR, SLT};

    typedef enum {K_ALU, K_ALUI, K_LUI, K_LW, K_SW, K_BR, K_JAL, K_JALR, K_ECALL} kind_t;

    logic clk, arstN, startProcess, endProcess;
    logic memReadMem, memWriteMem;
    instr_t instructionIF;
    word_t pcIF, dMOutMem, aluOutMem, rs2DataMem;

    instr_t imem [128];
    word_t dmem [128];
    word_t modelMem [128];
    word_t modelRegs [32];
    kind_t kind [progLen];
    aluOp_t op [progLen];
    branchType_t brType [progLen];
    regName_t rd [progLen];
    regName_t rs1 [progLen];
    regName_t rs2 [progLen];
    word_t imm [progLen];
    word_t expAddr [$];
    word_t expData [$];
    int storeIdx;
    int cycles;

    processor i_processor (
        .clk, .arstN, .startProcess, .endProcess, .instructionIF, .pcIF,
        .dMOutMem, .memReadMem, .memWriteMem, .aluOutMem, .rs2DataMem
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign instructionIF = imem[pcIF[8:2]];
    assign dMOutMem = dmem[aluOutMem[8:2]];

    always @(posedge clk) begin
        if (arstN && memWriteMem) begin
            dmem[aluOutMem[8:2]] <= rs2DataMem;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    task automatic reportFailure(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compareWord(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            reportFailure($sformatf("[FAIL] t=%0t %s: got %h, expected %h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic compareBit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            reportFailure($sformatf("[FAIL] t=%0t %s: got %b, expected %b",
                                    $time, name, actual, expected));
        end
    endtask

    // Store stream against the model, in order
    always @(negedge clk) begin
        if (i_processor.i_processor_asserts.failCount != 0) begin
            reportFailure("A bound assertion on the pipeline controls failed");
        end
        if (arstN) begin
            if (!startProcess) begin
                // PC parked at zero until started
                compareWord("pcIF", pcIF, '0);
                compareBit("memReadMem", memReadMem, 1'b0);
                compareBit("memWriteMem", memWriteMem, 1'b0);
            end
            if (memWriteMem) begin
                if (endProcess) begin
                    reportFailure("A store was performed after endProcess rose");
                end
                if (storeIdx >= expAddr.size()) begin
                    reportFailure("The core performed more stores than the ISA model");
                end
                compareWord("aluOutMem", aluOutMem, expAddr[storeIdx]);
                compareWord("rs2DataMem", rs2DataMem, expData[storeIdx]);
                storeIdx++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Program generation and encoding
    ////////////////////////////////////////////////////////////
    function automatic int pickTarget(int t);
        // Never land between the link ADDI and its JALR
        if (t < bodyLen && kind[t] == K_JALR) begin
            t++;
        end
        return (t > bodyLen) ? bodyLen : t;
    endfunction

    task automatic makeProgram();
        logic [11:0] rnd12;
        int pick;
        int tgt;
        logic pendingJalr;
        pendingJalr = 1'b0;
        for (int i = 0; i < progLen; i++) begin
            rnd12 = 12'($urandom);
            rd[i] = regName_t'($urandom_range(1, 7));
            rs1[i] = regName_t'($urandom_range(0, 7));
            rs2[i] = regName_t'($urandom_range(0, 7));
            imm[i] = {{20{rnd12[11]}}, rnd12};
            op[i] = aluOp_t'($urandom_range(0, 8));
            brType[i] = branchType_t'($urandom_range(0, 3));
            pick = $urandom_range(0, 99);
            if (i < 14) begin
                // Pool constants, LUI then ADDI
                kind[i] = (i % 2 == 1) ? K_ALUI : K_LUI;
                op[i] = ADD;
                rd[i] = regName_t'(i / 2 + 1);
                rs1[i] = rd[i];
                if (kind[i] == K_LUI) begin
                    imm[i] = $urandom & 32'hFFFF_F000;
                end
            end else if (pendingJalr) begin
                kind[i] = K_JALR;
                rs1[i] = linkReg;
                imm[i] = 32'd4;
                pendingJalr = 1'b0;
            end else if (i < bodyLen) begin
                if (pick < 35) begin
                    kind[i] = K_ALU;
                end else if (pick < 50) begin
                    kind[i] = K_ALUI;
                    op[i] = immOps[$urandom_range(0, 4)];
                end else if (pick < 74) begin
                    kind[i] = (pick < 62) ? K_LW : K_SW;
                    rs1[i] = '0;
                    imm[i] = word_t'($urandom_range(0, 63) * 4);
                end else if (pick < 88) begin
                    kind[i] = K_BR;
                end else if (pick < 94 || i + 1 >= bodyLen) begin
                    kind[i] = K_JAL;
                end else begin
                    // Link register written right before JALR
                    kind[i] = K_ALUI;
                    op[i] = ADD;
                    rd[i] = linkReg;
                    rs1[i] = '0;
                    pendingJalr = 1'b1;
                end
            end else if (i < progLen - 1) begin
                kind[i] = K_SW;
                rs1[i] = '0;
                rs2[i] = regName_t'(i - bodyLen + 1);
                imm[i] = word_t'((dumpBase + i - bodyLen) * 4);
            end else begin
                kind[i] = K_ECALL;
            end
        end
        // Forward-only targets once every slot kind is known
        for (int i = 14; i < bodyLen; i++) begin
            if (kind[i] == K_BR || kind[i] == K_JAL) begin
                tgt = pickTarget(i + 2 + $urandom_range(0, 2));
                imm[i] = word_t'((tgt - i) * 4);
            end else if (kind[i] == K_JALR) begin
                tgt = pickTarget(i + 1 + $urandom_range(0, 2));
                imm[i - 1] = word_t'(tgt * 4 - 4);
            end
        end
    endtask

    function automatic instr_t encodeSlot(int i);
        logic [2:0] f3;
        logic [2:0] bf3;
        logic [6:0] f7;
        word_t b;
        b = imm[i];
        f7 = (op[i] == SUB || op[i] == SRA) ? 7'b0100000 : 7'b0000000;
        case (op[i])
            SLL:      f3 = 3'b001;
            SLT:      f3 = 3'b010;
            XOR:      f3 = 3'b100;
            SRL, SRA: f3 = 3'b101;
            OR:       f3 = 3'b110;
            AND:      f3 = 3'b111;
            default:  f3 = 3'b000;
        endcase
        case (brType[i])
            NE:      bf3 = 3'b001;
            LT:      bf3 = 3'b100;
            GE:      bf3 = 3'b101;
            default: bf3 = 3'b000;
        endcase
        case (kind[i])
            K_ALU:   return {f7, rs2[i], rs1[i], f3, rd[i], OP};
            K_ALUI:  return {b[11:0], rs1[i], f3, rd[i], OPIMM};
            K_LUI:   return {b[31:12], rd[i], LUI};
            K_LW:    return {b[11:0], rs1[i], 3'b010, rd[i], LOAD};
            K_SW:    return {b[11:5], rs2[i], rs1[i], 3'b010, b[4:0], STORE};
            K_BR:    return {b[12], b[10:5], rs2[i], rs1[i], bf3, b[4:1], b[11], BRANCH};
            K_JAL:   return {b[20], b[10:1], b[11], b[19:12], rd[i], JAL};
            K_JALR:  return {b[11:0], rs1[i], 3'b000, rd[i], JALR};
            default: return 32'h0000_0073;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // ISA model
    ////////////////////////////////////////////////////////////
    function automatic word_t aluModel(aluOp_t o, word_t a, word_t b);
        case (o)
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $signed(a) >>> b[4:0];
            default: return a + b;
        endcase
    endfunction

    function automatic logic branchModel(branchType_t t, word_t a, word_t b);
        case (t)
            NE:      return a != b;
            LT:      return $signed(a) < $signed(b);
            GE:      return $signed(a) >= $signed(b);
            default: return a == b;
        endcase
    endfunction

    task automatic runModel();
        int pc;
        int next;
        int steps;
        word_t a, b, res, addr;
        pc = 0;
        steps = 0;
        modelRegs = '{default: '0};
        expAddr.delete();
        expData.delete();
        while (kind[pc] != K_ECALL) begin
            if (steps > 4 * progLen) begin
                reportFailure("The ISA model never reached ECALL");
            end
            a = modelRegs[rs1[pc]];
            b = modelRegs[rs2[pc]];
            addr = a + imm[pc];
            res = '0;
            next = pc + 1;
            case (kind[pc])
                K_ALU:  res = aluModel(op[pc], a, b);
                K_ALUI: res = aluModel(op[pc], a, imm[pc]);
                K_LUI:  res = imm[pc];
                K_LW:   res = modelMem[addr[8:2]];
                K_SW: begin
                    modelMem[addr[8:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                K_BR: begin
                    if (branchModel(brType[pc], a, b)) begin
                        next = pc + int'(imm[pc]) / 4;
                    end
                end
                K_JAL: begin
                    res = word_t'(4 * (pc + 1));
                    next = pc + int'(imm[pc]) / 4;
                end
                K_JALR: begin
                    res = word_t'(4 * (pc + 1));
                    next = int'(addr >> 2);
                end
                default: ;
            endcase
            if (kind[pc] inside {K_ALU, K_ALUI, K_LUI, K_LW, K_JAL, K_JALR} && rd[pc] != 0) begin
                modelRegs[rd[pc]] = res;
            end
            pc = next;
            steps++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    function automatic word_t fillWord(int t, int i);
        return (word_t'(i) * 32'h9E37_79B1) ^ (word_t'(t) << 24) ^ 32'h0F1E_2D3C;
    endfunction

    task automatic runTest(int t);
        int limit;
        int idle;
        makeProgram();
        for (int i = 0; i < 128; i++) begin
            imem[i] = (i < progLen) ? encodeSlot(i) : '0;
            dmem[i] <= fillWord(t, i);
            modelMem[i] = fillWord(t, i);
        end
        runModel();
        @(posedge clk);
        arstN <= 1'b0;
        startProcess <= 1'b0;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        storeIdx = 0;
        // Idle while started low, no memory access allowed
        idle = $urandom_range(2, 6);
        repeat (idle) @(posedge clk);
        startProcess <= 1'b1;
        limit = progLen * 4 + 100;
        cycles = 0;
        while (!endProcess) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                reportFailure($sformatf("Timeout in program %0d, the core never halted", t));
            end
        end
        if (storeIdx != expAddr.size()) begin
            reportFailure("endProcess rose before every expected store was seen");
        end
        repeat (10) @(negedge clk);
        for (int r = 1; r < 16; r++) begin
            compareWord($sformatf("dmem[%0d]", dumpBase + r - 1), dmem[dumpBase + r - 1],
                        modelRegs[r]);
        end
    endtask

    initial begin
        arstN = 1'b0;
        startProcess = 1'b0;
        storeIdx = 0;
        void'($urandom(32'h5858_3848));
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        if (i_processor.i_processor_asserts.failCount != 0) begin
            reportFailure("A bound assertion on the pipeline controls failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule : processorTb

// File: tests/processor_asserts.sv
`timescale 1ns/10ps

module processor_asserts (
    input logic clk,
    input logic arstN,
    input logic memReadMem,
    input logic memWriteMem,
    input logic endProcess
);

    int failCount = 0;

    // One word access per cycle at most
    strobesExclusive: assert property (
        @(posedge clk) disable iff (!arstN) !(memReadMem && memWriteMem)
    ) else begin
        $error("memReadMem and memWriteMem high together");
        failCount++;
    end

    // Leaving reset with the memory idle and no halt
    quietAfterReset: assert property (
        @(posedge clk) $rose(arstN) |-> !memReadMem && !memWriteMem && !endProcess
    ) else begin
        $error("Strobes or endProcess active right after reset");
        failCount++;
    end

    haltSticky: assert property (
        @(posedge clk) disable iff (!arstN) endProcess |=> endProcess
    ) else begin
        $error("endProcess dropped before reset");
        failCount++;
    end

endmodule : processor_asserts

bind processor processor_asserts i_processor_asserts (
    .clk, .arstN, .memReadMem, .memWriteMem, .endProcess
);

// File: design/processor.sv
`timescale 1ns/10ps

module processor import rvPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   startProcess,
    output logic   endProcess,
    input  instr_t instructionIF,
    output word_t  pcIF,
    input  word_t  dMOutMem,
    output logic   memReadMem,
    output logic   memWriteMem,
    output word_t  aluOutMem,
    output word_t  rs2DataMem
);

    // Fetch and decode
    instr_t instrId;
    word_t pcId, rs1DataId, rs2DataId, immI, immS, immB, immU, immJ;
    word_t cmpA, cmpB, jumpTarget, immId;
    logic regWriteId, memReadId, memWriteId, memToRegId, isLuiId;
    logic branchId, jumpId, jumpRegId, haltId, branchTaken;
    aluSrc2_t aluSrc2Id;
    aluOp_t aluOpId;
    branchType_t branchTypeId;
    logic pcWrite, ifIdWrite, idBubble, takeBranch, haltFetch, haltStop;
    // Execute
    logic regWriteEx, memReadEx, memWriteEx, memToRegEx, haltEx;
    aluSrc2_t aluSrc2Ex;
    aluOp_t aluOpEx;
    word_t rs1DataEx, rs2DataEx, immEx, retAddrEx, fwdOut1, fwdOut2, aluIn2, aluOutEx;
    regName_t rdEx, rs1Ex, rs2Ex;
    forwardSel_t forward1, forward2;
    logic branchFwd1, branchFwd2;
    // Memory and write-back
    logic regWriteMem, memToRegMem, haltMem, regWriteWb, memToRegWb;
    regName_t rdMem, rdWb;
    word_t aluOutWb, dMOutWb, dataInWb;

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////
    assign haltStop = haltFetch || haltId;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcIF <= '0;
            haltFetch <= 1'b0;
            instrId <= '0;
            pcId <= '0;
        end else begin
            haltFetch <= haltStop;
            if (startProcess && !haltStop) begin
                if (takeBranch) begin
                    pcIF <= jumpTarget;
                end else if (pcWrite) begin
                    pcIF <= pcIF + word_t'(4);
                end
            end
            // All-zero instruction decodes as a bubble
            if (ifIdWrite) begin
                instrId <= (startProcess && !takeBranch && !haltStop) ? instructionIF : '0;
                pcId <= pcIF;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode with branch resolution
    ////////////////////////////////////////////////////////////
    controlUnit i_controlUnit (
        .opCode(opCode_t'(instrId[6:0])), .func3(instrId[14:12]), .func7(instrId[31:25]),
        .regWrite(regWriteId), .memRead(memReadId), .memWrite(memWriteId),
        .memToReg(memToRegId), .aluSrc2(aluSrc2Id), .aluOp(aluOpId), .isLui(isLuiId),
        .branch(branchId), .jump(jumpId), .jumpReg(jumpRegId),
        .branchType(branchTypeId), .halt(haltId)
    );

    regFile i_regFile (
        .clk, .arstN, .wen(regWriteWb), .rd(rdWb), .dataIn(dataInWb),
        .rs1(instrId[19:15]), .rs2(instrId[24:20]), .rs1Data(rs1DataId), .rs2Data(rs2DataId)
    );

    immExtend i_immExtend (
        .instruction(instrId), .immI, .immS, .immB, .immU, .immJ
    );

    hazardUnit i_hazardUnit (
        .rs1Id(instrId[19:15]), .rs2Id(instrId[24:20]), .rdEx, .regWriteEx, .memReadEx,
        .rdMem, .memReadMem, .branch(branchId), .jumpReg(jumpRegId),
        .pcWrite, .ifIdWrite, .idBubble
    );

    assign cmpA = branchFwd1 ? aluOutMem : rs1DataId;
    assign cmpB = branchFwd2 ? aluOutMem : rs2DataId;
    assign jumpTarget = ((jumpRegId ? cmpA : pcId)
                        + (jumpRegId ? immI : (jumpId ? immJ : immB))) & ~word_t'(1);
    // Never redirect on operands that are still stalled
    assign takeBranch = pcWrite && (jumpId || jumpRegId || (branchId && branchTaken));
    assign immId = isLuiId ? immU : (memWriteId ? immS : immI);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {regWriteEx, memReadEx, memWriteEx, memToRegEx, haltEx} <= '0;
            aluSrc2Ex <= SRC_REG;
            aluOpEx <= ADD;
            {rs1DataEx, rs2DataEx, immEx, retAddrEx} <= '0;
            {rdEx, rs1Ex, rs2Ex} <= '0;
        end else begin
            {regWriteEx, memReadEx, memWriteEx, memToRegEx, haltEx} <= idBubble ? 5'b0
                : {regWriteId, memReadId, memWriteId, memToRegId, haltId};
            aluSrc2Ex <= aluSrc2Id;
            aluOpEx <= aluOpId;
            rs1DataEx <= rs1DataId;
            rs2DataEx <= rs2DataId;
            immEx <= immId;
            retAddrEx <= pcId + word_t'(4);
            rdEx <= instrId[11:7];
            rs1Ex <= instrId[19:15];
            rs2Ex <= instrId[24:20];
        end
    end

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////
    forwardUnit i_forwardUnit (
        .rs1Ex, .rs2Ex, .rs1Id(instrId[19:15]), .rs2Id(instrId[24:20]),
        .rdMem, .regWriteMem, .memReadMem, .rdWb, .regWriteWb,
        .forward1, .forward2, .branchFwd1, .branchFwd2
    );

    function automatic word_t fwdMux(forwardSel_t sel, word_t regVal);
        case (sel)
            FWD_MEM: return aluOutMem;
            FWD_WB:  return dataInWb;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        fwdOut1 = fwdMux(forward1, rs1DataEx);
        fwdOut2 = fwdMux(forward2, rs2DataEx);
    end

    always_comb begin
        case (aluSrc2Ex)
            SRC_IMM: aluIn2 = immEx;
            SRC_PC4: aluIn2 = retAddrEx;
            default: aluIn2 = fwdOut2;
        endcase
    end

    alu i_alu (
        .busA(fwdOut1), .busB(aluIn2), .aluOp(aluOpEx), .cmpA, .cmpB,
        .branchType(branchTypeId), .result(aluOutEx), .branchTaken
    );

    ////////////////////////////////////////////////////////////
    // Memory, write-back and halt
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {regWriteMem, memReadMem, memWriteMem, memToRegMem, haltMem} <= '0;
            {aluOutMem, rs2DataMem, rdMem} <= '0;
            {regWriteWb, memToRegWb, aluOutWb, dMOutWb, rdWb} <= '0;
            endProcess <= 1'b0;
        end else begin
            {regWriteMem, memReadMem, memWriteMem, memToRegMem, haltMem}
                <= {regWriteEx, memReadEx, memWriteEx, memToRegEx, haltEx};
            aluOutMem <= aluOutEx;
            rs2DataMem <= fwdOut2;
            rdMem <= rdEx;
            regWriteWb <= regWriteMem;
            memToRegWb <= memToRegMem;
            aluOutWb <= aluOutMem;
            dMOutWb <= dMOutMem;
            rdWb <= rdMem;
            // Rises as ECALL enters write-back, held until reset
            endProcess <= endProcess || haltMem;
        end
    end

    assign dataInWb = memToRegWb ? dMOutWb : aluOutWb;

endmodule : processor

// File: design/alu.sv
`timescale 1ns/10ps

module alu import rvPkg::*; (
    input  word_t       busA,
    input  word_t       busB,
    input  aluOp_t      aluOp,
    input  word_t       cmpA,
    input  word_t       cmpB,
    input  branchType_t branchType,
    output word_t       result,
    output logic        branchTaken
);

    logic [4:0] shamt;

    assign shamt = busB[4:0];

    always_comb begin
        case (aluOp)
            ADD:     result = busA + busB;
            SUB:     result = busA - busB;
            AND:     result = busA & busB;
            OR:      result = busA | busB;
            XOR:     result = busA ^ busB;
            SLT:     result = word_t'($signed(busA) < $signed(busB));
            SLL:     result = busA << shamt;
            SRL:     result = busA >> shamt;
            SRA:     result = word_t'($signed(busA) >>> shamt);
            PASSB:   result = busB;
            default: result = '0;
        endcase
    end

    // Decode-stage compare, independent of the execute operation
    always_comb begin
        case (branchType)
            EQ:      branchTaken = (cmpA == cmpB);
            NE:      branchTaken = (cmpA != cmpB);
            LT:      branchTaken = ($signed(cmpA) < $signed(cmpB));
            GE:      branchTaken = ($signed(cmpA) >= $signed(cmpB));
            default: branchTaken = 1'b0;
        endcase
    end

endmodule : alu

// File: design/forwardUnit.sv
`timescale 1ns/10ps

module forwardUnit import rvPkg::*; (
    input  regName_t    rs1Ex,
    input  regName_t    rs2Ex,
    input  regName_t    rs1Id,
    input  regName_t    rs2Id,
    input  regName_t    rdMem,
    input  logic        regWriteMem,
    input  logic        memReadMem,
    input  regName_t    rdWb,
    input  logic        regWriteWb,
    output forwardSel_t forward1,
    output forwardSel_t forward2,
    output logic        branchFwd1,
    output logic        branchFwd2
);

    logic memAluValid;
    logic wbValid;

    // A load in memory has no result on the ALU path
    assign memAluValid = regWriteMem && !memReadMem && rdMem != '0;
    assign wbValid = regWriteWb && rdWb != '0;

    function automatic forwardSel_t pickSource(regName_t rs);
        if (memAluValid && rdMem == rs) begin
            return FWD_MEM;
        end else if (wbValid && rdWb == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        forward1 = pickSource(rs1Ex);
        forward2 = pickSource(rs2Ex);
    end

    // Decode sources, write-back is covered by the register file bypass
    assign branchFwd1 = memAluValid && rdMem == rs1Id;
    assign branchFwd2 = memAluValid && rdMem == rs2Id;

endmodule : forwardUnit

// File: design/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit import rvPkg::*; (
    input  regName_t rs1Id,
    input  regName_t rs2Id,
    input  regName_t rdEx,
    input  logic     regWriteEx,
    input  logic     memReadEx,
    input  regName_t rdMem,
    input  logic     memReadMem,
    input  logic     branch,
    input  logic     jumpReg,
    output logic     pcWrite,
    output logic     ifIdWrite,
    output logic     idBubble
);

    logic hitEx1, hitEx2;
    logic hitMem1, hitMem2;
    logic loadUse, branchOnEx, branchOnLoad;
    logic stall;

    // JALR compares nothing but still needs rs1 in decode
    assign hitEx1 = regWriteEx && rs1Id != '0 && rs1Id == rdEx;
    assign hitEx2 = regWriteEx && rs2Id != '0 && rs2Id == rdEx;
    assign hitMem1 = memReadMem && rs1Id != '0 && rs1Id == rdMem;
    assign hitMem2 = memReadMem && rs2Id != '0 && rs2Id == rdMem;

    assign loadUse = memReadEx && (hitEx1 || hitEx2);
    assign branchOnEx = ((branch || jumpReg) && hitEx1) || (branch && hitEx2);
    // Load data is only ready for decode once the load reaches write-back
    assign branchOnLoad = ((branch || jumpReg) && hitMem1) || (branch && hitMem2);

    assign stall = loadUse || branchOnEx || branchOnLoad;

    assign pcWrite = !stall;
    assign ifIdWrite = !stall;
    assign idBubble = stall;

endmodule : hazardUnit

// File: design/immExtend.sv
`timescale 1ns/10ps

module immExtend import rvPkg::*; (
    input  instr_t instruction,
    output word_t  immI,
    output word_t  immS,
    output word_t  immB,
    output word_t  immU,
    output word_t  immJ
);

    logic sign;

    assign sign = instruction[31];

    assign immI = {{20{sign}}, instruction[31:20]};
    assign immS = {{20{sign}}, instruction[31:25], instruction[11:7]};

    // B and J keep bit 0 at zero, targets are halfword aligned
    assign immB = {{19{sign}}, sign, instruction[7], instruction[30:25],
                   instruction[11:8], 1'b0};
    assign immJ = {{11{sign}}, sign, instruction[19:12], instruction[20],
                   instruction[30:21], 1'b0};

    assign immU = {instruction[31:12], 12'b0};

endmodule : immExtend

// File: design/regFile.sv
`timescale 1ns/10ps

module regFile import rvPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     wen,
    input  regName_t rd,
    input  word_t    dataIn,
    input  regName_t rs1,
    input  regName_t rs2,
    output word_t    rs1Data,
    output word_t    rs2Data
);

    word_t regs [regCount];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= dataIn;
        end
    end

    // Write-back value bypasses the array in the same cycle
    assign rs1Data = (wen && rd != '0 && rd == rs1) ? dataIn : regs[rs1];
    assign rs2Data = (wen && rd != '0 && rd == rs2) ? dataIn : regs[rs2];

endmodule : regFile

// File: design/controlUnit.sv
`timescale 1ns/10ps

module controlUnit import rvPkg::*; (
    input  opCode_t     opCode,
    input  logic [2:0]  func3,
    input  logic [6:0]  func7,
    output logic        regWrite,
    output logic        memRead,
    output logic        memWrite,
    output logic        memToReg,
    output aluSrc2_t    aluSrc2,
    output aluOp_t      aluOp,
    output logic        isLui,
    output logic        branch,
    output logic        jump,
    output logic        jumpReg,
    output branchType_t branchType,
    output logic        halt
);

    always_comb begin
        // No-operation unless the opcode says otherwise
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc2 = SRC_REG;
        aluOp = ADD;
        isLui = 1'b0;
        branch = 1'b0;
        jump = 1'b0;
        jumpReg = 1'b0;
        branchType = EQ;
        halt = 1'b0;

        case (opCode)
            OP, OPIMM: begin
                regWrite = 1'b1;
                aluSrc2 = (opCode == OP) ? SRC_REG : SRC_IMM;
                case (func3)
                    f3AddSub: aluOp = (opCode == OP && func7[func7AltBit]) ? SUB : ADD;
                    f3Sll:    aluOp = SLL;
                    f3Slt:    aluOp = SLT;
                    f3Xor:    aluOp = XOR;
                    f3Shr:    aluOp = func7[func7AltBit] ? SRA : SRL;
                    f3Or:     aluOp = OR;
                    f3And:    aluOp = AND;
                    default:  aluOp = ADD;
                endcase
            end
            LUI: begin
                regWrite = 1'b1;
                aluSrc2 = SRC_IMM;
                aluOp = PASSB;
                isLui = 1'b1;
            end
            LOAD: begin
                regWrite = 1'b1;
                memRead = 1'b1;
                memToReg = 1'b1;
                aluSrc2 = SRC_IMM;
            end
            STORE: begin
                memWrite = 1'b1;
                aluSrc2 = SRC_IMM;
            end
            BRANCH: begin
                branch = 1'b1;
                case (func3)
                    f3Bne:   branchType = NE;
                    f3Blt:   branchType = LT;
                    f3Bge:   branchType = GE;
                    default: branchType = EQ;
                endcase
            end
            JAL, JALR: begin
                // Link address goes down the pipe as operand B
                regWrite = 1'b1;
                aluSrc2 = SRC_PC4;
                aluOp = PASSB;
                jump = (opCode == JAL);
                jumpReg = (opCode == JALR);
            end
            SYSTEM: halt = 1'b1;
            default: ;
        endcase
    end

endmodule : controlUnit

// File: design/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;
    localparam int regCount = 32;
    localparam int regIdxWidth = $clog2(regCount);

    // Function field codes of the supported subset
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Shr = 3'b101;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;
    // Bit of func7 that selects SUB and SRA
    localparam int func7AltBit = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-1:0] instr_t;
    typedef logic [regIdxWidth-1:0] regName_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OPIMM  = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        SYSTEM = 7'b1110011
    } opCode_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, SRA, PASSB
    } aluOp_t;

    // Second ALU operand, PC4 is the link address of JAL and JALR
    typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_PC4} aluSrc2_t;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} forwardSel_t;

    typedef enum logic [1:0] {EQ, NE, LT, GE} branchType_t;

endpackage : rvPkg
